// File: exe_pkg.sv
`default_nettype none

package exe_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,  // signed compare.
        OP_ADDI, // rj + sext(imm).
        OP_MUL,  // low word, completes in ex2.
        OP_DIV,  // unsigned, lane 0 only.
        OP_NOP
    } exe_op_e;

    typedef struct packed {
        logic              valid;
        exe_op_e           op;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rk;
        logic [15:0]       imm;
    } lane_op_t;

    typedef struct packed {
        lane_op_t lane1;
        lane_op_t lane0;
    } issue_bundle_t;

    typedef struct packed {
        logic              valid;
        exe_op_e           op;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
        logic              data_valid; // low while a multiply is still in flight.
    } stage_lane_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wb_lane_t;

    typedef enum logic [1:0] {
        CS_RUN,
        CS_DIV_BUSY,
        CS_DIV_DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: ex1_forward.sv
`timescale 1ns/1ps
`default_nettype none

module ex1_forward (
    input  logic [exe_pkg::REG_AW-1:0]     rj_i,
    input  logic [exe_pkg::REG_AW-1:0]     rk_i,
    input  logic [exe_pkg::XLEN-1:0]       rj_data_i,
    input  logic [exe_pkg::XLEN-1:0]       rk_data_i,
    input  exe_pkg::stage_lane_t [1:0]     ex2_i,
    input  exe_pkg::stage_lane_t [1:0]     wb_i,
    output logic [exe_pkg::XLEN-1:0]       rj_data_o,
    output logic [exe_pkg::XLEN-1:0]       rk_data_o,
    output logic                           fwd_stall_o
);

    exe_pkg::stage_lane_t [3:0] src;
    logic                       rj_stall;
    logic                       rk_stall;

    // index 0 is the youngest producer and wins.
    assign src = {wb_i[0], wb_i[1], ex2_i[0], ex2_i[1]};

    function automatic void fwd_one(
        input  logic [exe_pkg::REG_AW-1:0] r,
        input  logic [exe_pkg::XLEN-1:0]   rf_data,
        input  exe_pkg::stage_lane_t [3:0] s,
        output logic [exe_pkg::XLEN-1:0]   data,
        output logic                       stall
    );
        logic hit;
        hit   = 1'b0;
        data  = rf_data;
        stall = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (!hit && r != '0 && s[i].valid && s[i].rd == r) begin
                hit = 1'b1;
                if (s[i].data_valid) begin
                    data = s[i].data;
                end else begin
                    stall = 1'b1; // producer not done yet.
                end
            end
        end
    endfunction

    always_comb begin
        fwd_one(rj_i, rj_data_i, src, rj_data_o, rj_stall);
        fwd_one(rk_i, rk_data_i, src, rk_data_o, rk_stall);
    end

    // either operand stalls the lane.
    assign fwd_stall_o = rj_stall | rk_stall;

endmodule

`default_nettype wire

// File: exe_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
    input  exe_pkg::exe_op_e         op_i,
    input  logic [exe_pkg::XLEN-1:0] a_i,
    input  logic [exe_pkg::XLEN-1:0] b_i,
    input  logic [15:0]              imm_i,
    output logic [exe_pkg::XLEN-1:0] result_o,
    output logic                     result_valid_o
);

    logic [exe_pkg::XLEN-1:0] imm_sext;

    assign imm_sext = {{(exe_pkg::XLEN-16){imm_i[15]}}, imm_i};

    always_comb begin
        result_o       = '0;
        result_valid_o = 1'b1;
        case (op_i)
            exe_pkg::OP_ADD:  result_o = a_i + b_i;
            exe_pkg::OP_SUB:  result_o = a_i - b_i;
            exe_pkg::OP_AND:  result_o = a_i & b_i;
            exe_pkg::OP_OR:   result_o = a_i | b_i;
            exe_pkg::OP_XOR:  result_o = a_i ^ b_i;
            exe_pkg::OP_SLT:  result_o = {{(exe_pkg::XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            exe_pkg::OP_ADDI: result_o = a_i + imm_sext;
            exe_pkg::OP_MUL: begin
                result_o       = a_i * b_i; // low word only.
                result_valid_o = 1'b0;      // counted as ready in ex2.
            end
            exe_pkg::OP_DIV:  result_valid_o = 1'b0; // quotient comes from the divider.
            default:          result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: exe_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module exe_regfile (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [3:0][exe_pkg::REG_AW-1:0]     raddr_i,
    input  exe_pkg::wb_lane_t [1:0]             wr_i,
    output logic [3:0][exe_pkg::XLEN-1:0]       rdata_o
);

    localparam int NREGS = 1 << exe_pkg::REG_AW;

    logic [exe_pkg::XLEN-1:0] regs_q [NREGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int r = 0; r < NREGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            // lane 1 is written last and wins a conflict.
            for (int w = 0; w < 2; w++) begin
                if (wr_i[w].valid && wr_i[w].rd != '0) begin
                    regs_q[wr_i[w].rd] <= wr_i[w].data;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs_q[raddr_i[p]]; // r0 reads zero.
        end
    end

endmodule

`default_nettype wire

// File: exe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl #(
    parameter int DIV_CYCLES = 32
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic ex1_valid_i,
    input  logic ex1_is_div_i,
    input  logic fwd_stall_i,
    input  logic div_done_i,
    output logic div_start_o,
    output logic ex1_hold_o,
    output logic issue_ready_o
);

    exe_pkg::ctrl_state_e state_q;
    exe_pkg::ctrl_state_e state_d;

    if (DIV_CYCLES < 1 || DIV_CYCLES > exe_pkg::XLEN) begin : g_bad_div_cycles
        $error("DIV_CYCLES must lie in 1..XLEN");
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= exe_pkg::CS_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        div_start_o = 1'b0;
        ex1_hold_o  = 1'b0;
        case (state_q)
            exe_pkg::CS_RUN: begin
                if (ex1_valid_i && fwd_stall_i) begin
                    ex1_hold_o = 1'b1;
                end else if (ex1_valid_i && ex1_is_div_i) begin
                    div_start_o = 1'b1; // operands are final here.
                    ex1_hold_o  = 1'b1;
                    state_d     = exe_pkg::CS_DIV_BUSY;
                end
            end
            exe_pkg::CS_DIV_BUSY: begin
                ex1_hold_o = 1'b1;
                if (div_done_i) begin
                    state_d = exe_pkg::CS_DIV_DONE;
                end
            end
            exe_pkg::CS_DIV_DONE: state_d = exe_pkg::CS_RUN; // one advance with the quotient.
            default:              state_d = exe_pkg::CS_RUN;
        endcase
    end

    assign issue_ready_o = ~ex1_hold_o;

endmodule

`default_nettype wire

// File: div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
    parameter int DIV_CYCLES = 32
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic [exe_pkg::XLEN-1:0] dividend_i,
    input  logic [exe_pkg::XLEN-1:0] divisor_i,
    output logic                     done_o,
    output logic [exe_pkg::XLEN-1:0] quotient_o
);

    localparam int XLEN = exe_pkg::XLEN;
    localparam int CW   = $clog2(DIV_CYCLES + 1);

    logic [CW-1:0]   cnt_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] dvs_q;
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;

    // next remainder bit comes from the top of the quotient shifter.
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= CW'(DIV_CYCLES);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rem_q <= '0;
            quo_q <= dividend_i << (XLEN - DIV_CYCLES); // only the low DIV_CYCLES bits.
            dvs_q <= divisor_i;
        end else if (cnt_q != '0) begin
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[XLEN-1:0]; // restore.
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // last iteration runs in this cycle, the quotient is final after it.
    assign done_o     = (cnt_q == CW'(1));
    assign quotient_o = quo_q;

endmodule

`default_nettype wire

// File: exe_top.sv
`timescale 1ns/1ps
`default_nettype none

module exe_top #(
    parameter int DIV_CYCLES = 32
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    issue_valid_i,
    input  exe_pkg::issue_bundle_t  issue_i,
    output logic                    issue_ready_o,
    output exe_pkg::wb_lane_t [1:0] wb_o
);

    localparam int XLEN = exe_pkg::XLEN;

    exe_pkg::issue_bundle_t            ex1_q;
    exe_pkg::lane_op_t [1:0]           ex1_lane;
    exe_pkg::stage_lane_t [1:0]        ex2_q;
    exe_pkg::stage_lane_t [1:0]        wb_q;
    logic [1:0][XLEN-1:0]              ex2_a_q;
    logic [1:0][XLEN-1:0]              ex2_b_q;
    logic [3:0][exe_pkg::REG_AW-1:0]   rf_raddr;
    logic [3:0][XLEN-1:0]              rf_rdata;
    logic [1:0][XLEN-1:0]              opa;
    logic [1:0][XLEN-1:0]              opb;
    logic [1:0][XLEN-1:0]              ex1_res;
    logic [1:0][XLEN-1:0]              mul_res;
    logic [1:0]                        ex1_res_valid;
    logic [1:0]                        lane_stall;
    logic                              ex1_valid;
    logic                              ex1_is_div;
    logic                              ex1_hold;
    logic                              fwd_stall;
    logic                              div_start;
    logic                              div_done;
    logic [XLEN-1:0]                   quotient;

    assign ex1_lane   = {ex1_q.lane1, ex1_q.lane0};
    assign ex1_valid  = ex1_q.lane0.valid | ex1_q.lane1.valid;
    assign ex1_is_div = ex1_q.lane0.valid && (ex1_q.lane0.op == exe_pkg::OP_DIV);
    assign fwd_stall  = (ex1_q.lane0.valid & lane_stall[0]) | (ex1_q.lane1.valid & lane_stall[1]);
    assign rf_raddr   = {ex1_q.lane1.rk, ex1_q.lane1.rj, ex1_q.lane0.rk, ex1_q.lane0.rj};

    always_ff @(posedge clk_i) begin
        if (!ex1_hold) begin
            ex1_q <= issue_i;
        end
        if (rst_i) begin
            ex1_q.lane0.valid <= 1'b0;
            ex1_q.lane1.valid <= 1'b0;
        end else if (!ex1_hold) begin
            ex1_q.lane0.valid <= issue_valid_i && issue_i.lane0.valid;
            ex1_q.lane1.valid <= issue_valid_i && issue_i.lane1.valid;
        end
    end

    for (genvar l = 0; l < 2; l++) begin : g_lane
        ex1_forward ex1_forward_i (
            .rj_i        (ex1_lane[l].rj),
            .rk_i        (ex1_lane[l].rk),
            .rj_data_i   (rf_rdata[2*l]),
            .rk_data_i   (rf_rdata[2*l+1]),
            .ex2_i       (ex2_q),
            .wb_i        (wb_q),
            .rj_data_o   (opa[l]),
            .rk_data_o   (opb[l]),
            .fwd_stall_o (lane_stall[l])
        );

        exe_alu alu_ex1_i (
            .op_i           (ex1_lane[l].op),
            .a_i            (opa[l]),
            .b_i            (opb[l]),
            .imm_i          (ex1_lane[l].imm),
            .result_o       (ex1_res[l]),
            .result_valid_o (ex1_res_valid[l])
        );

        // multiply completion only.
        exe_alu alu_ex2_i (
            .op_i           (ex2_q[l].op),
            .a_i            (ex2_a_q[l]),
            .b_i            (ex2_b_q[l]),
            .imm_i          (16'h0000),
            .result_o       (mul_res[l]),
            .result_valid_o ()
        );
    end

    always_ff @(posedge clk_i) begin
        for (int l = 0; l < 2; l++) begin
            ex2_q[l].op         <= ex1_lane[l].op;
            ex2_q[l].rd         <= ex1_lane[l].rd;
            ex2_q[l].data       <= ((l == 0) && ex1_is_div) ? quotient : ex1_res[l];
            ex2_q[l].data_valid <= ex1_res_valid[l] || ((l == 0) && ex1_is_div);
            ex2_a_q[l]          <= opa[l];
            ex2_b_q[l]          <= opb[l];
            wb_q[l].op          <= ex2_q[l].op;
            wb_q[l].rd          <= ex2_q[l].rd;
            wb_q[l].data        <= ex2_q[l].data_valid ? ex2_q[l].data : mul_res[l];
            wb_q[l].data_valid  <= 1'b1;
        end
        if (rst_i) begin
            for (int l = 0; l < 2; l++) begin
                ex2_q[l].valid <= 1'b0;
                wb_q[l].valid  <= 1'b0;
            end
        end else begin
            for (int l = 0; l < 2; l++) begin
                // a hold sends a bubble, a nop never writes back.
                ex2_q[l].valid <= !ex1_hold && ex1_lane[l].valid &&
                                  (ex1_lane[l].op != exe_pkg::OP_NOP);
                wb_q[l].valid  <= ex2_q[l].valid;
            end
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            wb_o[l].valid = wb_q[l].valid;
            wb_o[l].rd    = wb_q[l].rd;
            wb_o[l].data  = wb_q[l].data;
        end
    end

    exe_ctrl #(
        .DIV_CYCLES (DIV_CYCLES)
    ) exe_ctrl_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .ex1_valid_i   (ex1_valid),
        .ex1_is_div_i  (ex1_is_div),
        .fwd_stall_i   (fwd_stall),
        .div_done_i    (div_done),
        .div_start_o   (div_start),
        .ex1_hold_o    (ex1_hold),
        .issue_ready_o (issue_ready_o)
    );

    div_unit #(
        .DIV_CYCLES (DIV_CYCLES)
    ) div_unit_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .dividend_i (opa[0]),
        .divisor_i  (opb[0]),
        .done_o     (div_done),
        .quotient_o (quotient)
    );

    exe_regfile exe_regfile_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .raddr_i (rf_raddr),
        .wr_i    (wb_o),
        .rdata_o (rf_rdata)
    );

endmodule

`default_nettype wire

// File: exe_top_props.sv
`timescale 1ns/1ps
`default_nettype none

module exe_top_props (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    issue_ready_i,
    input logic                    div_start_i,
    input logic                    div_done_i,
    input exe_pkg::ctrl_state_e    state_i,
    input exe_pkg::wb_lane_t [1:0] wb_i
);

    logic div_pend_q; // a divide was started and has not finished.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            div_pend_q <= 1'b0;
        end else if (div_start_i) begin
            div_pend_q <= 1'b1;
        end else if (div_done_i) begin
            div_pend_q <= 1'b0;
        end
    end

    a_ready_low_in_div: assert property (@(posedge clk_i) disable iff (rst_i)
        state_i == exe_pkg::CS_DIV_BUSY |-> !issue_ready_i)
        else $error("issue_ready_o high while a divide is busy");

    a_no_wb_after_reset: assert property (@(posedge clk_i)
        $fell(rst_i) |-> !wb_i[0].valid && !wb_i[1].valid)
        else $error("writeback valid in the first cycle after reset");

    a_done_after_start: assert property (@(posedge clk_i) disable iff (rst_i)
        div_done_i |-> div_pend_q)
        else $error("divider done without a preceding start");

endmodule

bind exe_top exe_top_props exe_top_props_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_ready_i (issue_ready_o),
    .div_start_i   (div_start),
    .div_done_i    (div_done),
    .state_i       (exe_ctrl_i.state_q),
    .wb_i          (wb_o)
);

`default_nettype wire

// File: tb_exe_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exe_top;

    localparam int CLK_NS      = 10;
    localparam int DIV_CYCLES  = 32;
    localparam int DRAIN_LIMIT = 100;

    typedef struct packed {
        logic        lane;
        logic        exact; // latency must be exactly two cycles.
        logic [4:0]  rd;
        logic [31:0] data;
        logic [63:0] due;
    } wb_expect_t;

    localparam exe_pkg::lane_op_t NO_OP = '0;

    logic                    clk_i = 1'b0;
    logic                    rst_i;
    logic                    issue_valid_i;
    exe_pkg::issue_bundle_t  issue_i;
    logic                    issue_ready_o;
    exe_pkg::wb_lane_t [1:0] wb_o;

    logic [31:0] model_q [32];
    wb_expect_t  exp_q [$];
    wb_expect_t  mon_e;
    int          errors   = 0;
    int          checks   = 0;
    int          bundles  = 0;

    exe_top #(
        .DIV_CYCLES (DIV_CYCLES)
    ) exe_top_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .wb_o          (wb_o)
    );

    always #(CLK_NS / 2) clk_i = ~clk_i;

    function automatic logic [15:0] rnd16();
        return 16'($urandom());
    endfunction

    function automatic exe_pkg::lane_op_t make_op(input exe_pkg::exe_op_e op, input int rd,
                                                  input int rj, input int rk,
                                                  input logic [15:0] imm);
        exe_pkg::lane_op_t o;
        o.valid = 1'b1;
        o.op    = op;
        o.rd    = 5'(rd);
        o.rj    = 5'(rj);
        o.rk    = 5'(rk);
        o.imm   = imm;
        return o;
    endfunction

    // architectural result of one operation.
    function automatic logic [31:0] expect_result(input exe_pkg::exe_op_e op,
                                                  input logic [31:0] a, input logic [31:0] b,
                                                  input logic [15:0] imm);
        case (op)
            exe_pkg::OP_ADD:  return a + b;
            exe_pkg::OP_SUB:  return a - b;
            exe_pkg::OP_AND:  return a & b;
            exe_pkg::OP_OR:   return a | b;
            exe_pkg::OP_XOR:  return a ^ b;
            exe_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::OP_ADDI: return a + {{16{imm[15]}}, imm};
            exe_pkg::OP_MUL:  return a * b;
            exe_pkg::OP_DIV:  return (b == 32'd0) ? 32'hffff_ffff : a / b;
            default:          return 32'd0;
        endcase
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // presents a bundle, waits for the handshake and updates the model.
    task automatic issue_bundle(input exe_pkg::lane_op_t l0, input exe_pkg::lane_op_t l1,
                                input bit exact, output int waited);
        exe_pkg::lane_op_t lanes [2];
        wb_expect_t        e;
        bundles++;
        lanes[0]       = l0;
        lanes[1]       = l1;
        issue_i.lane0  = l0;
        issue_i.lane1  = l1;
        issue_valid_i  = 1'b1;
        waited         = 0;
        @(negedge clk_i);
        while (!issue_ready_o) begin
            waited++;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        for (int l = 0; l < 2; l++) begin
            if (lanes[l].valid && lanes[l].op != exe_pkg::OP_NOP) begin
                e.lane  = 1'(l);
                e.exact = exact;
                e.rd    = lanes[l].rd;
                e.data  = expect_result(lanes[l].op, model_q[lanes[l].rj],
                                        model_q[lanes[l].rk], lanes[l].imm);
                e.due   = $time + 2 * CLK_NS + CLK_NS / 2;
                exp_q.push_back(e);
                if (lanes[l].rd != 5'd0) model_q[lanes[l].rd] = e.data;
            end
        end
        #1 issue_valid_i = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d expected writebacks never appeared", exp_q.size());
            exp_q.delete();
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_ready(input logic exp_v);
        @(negedge clk_i);
        checks++;
        if (issue_ready_o !== exp_v) begin
            errors++;
            $display("FAIL %0t ns: issue_ready_o expected %b got %b", $time, exp_v, issue_ready_o);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic apply_reset(input int cycles);
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        exp_q.delete();
        for (int r = 0; r < 32; r++) model_q[r] = 32'd0;
        repeat (cycles) @(posedge clk_i);
        #1 rst_i = 1'b0;
    endtask

    task automatic independent_ops();
        int w;
        issue_bundle(make_op(exe_pkg::OP_ADDI, 1, 0, 0, rnd16()),
                     make_op(exe_pkg::OP_ADDI, 2, 0, 0, rnd16()), 1, w);
        issue_bundle(make_op(exe_pkg::OP_ADDI, 3, 0, 0, 16'h7fff),
                     make_op(exe_pkg::OP_ADDI, 4, 0, 0, 16'h8000), 1, w);
        drain();
        issue_bundle(make_op(exe_pkg::OP_ADD, 5, 1, 2, 0), make_op(exe_pkg::OP_ADD, 6, 3, 4, 0), 1, w);
        drain();
    endtask

    task automatic forwarding_paths();
        int w;
        issue_bundle(make_op(exe_pkg::OP_ADDI, 5, 0, 0, rnd16()),
                     make_op(exe_pkg::OP_ADDI, 6, 0, 0, rnd16()), 1, w);
        issue_bundle(make_op(exe_pkg::OP_ADD, 7, 5, 6, 0), make_op(exe_pkg::OP_SUB, 8, 6, 5, 0), 1, w);
        issue_bundle(make_op(exe_pkg::OP_XOR, 9, 7, 5, 0), make_op(exe_pkg::OP_OR, 10, 6, 8, 0), 1, w);
        issue_bundle(make_op(exe_pkg::OP_SLT, 11, 9, 10, 0),
                     make_op(exe_pkg::OP_AND, 12, 8, 7, 0), 1, w);
        // both lanes write r13, lane 1 must win from ex2 and from wb.
        issue_bundle(make_op(exe_pkg::OP_ADDI, 13, 0, 0, rnd16()),
                     make_op(exe_pkg::OP_ADDI, 13, 0, 0, rnd16()), 1, w);
        issue_bundle(make_op(exe_pkg::OP_ADD, 14, 13, 0, 0),
                     make_op(exe_pkg::OP_ADDI, 15, 13, 0, 16'd1), 1, w);
        issue_bundle(NO_OP, make_op(exe_pkg::OP_SUB, 16, 13, 14, 0), 1, w);
        issue_bundle(make_op(exe_pkg::OP_ADDI, 17, 0, 0, rnd16()), NO_OP, 1, w);
        issue_bundle(make_op(exe_pkg::OP_ADDI, 17, 0, 0, rnd16()), NO_OP, 1, w);
        issue_bundle(make_op(exe_pkg::OP_ADD, 18, 17, 17, 0), NO_OP, 1, w);
        drain();
    endtask

    task automatic mul_stall();
        int w;
        issue_bundle(make_op(exe_pkg::OP_MUL, 20, 5, 6, 0),
                     make_op(exe_pkg::OP_ADDI, 21, 0, 0, rnd16()), 1, w);
        issue_bundle(make_op(exe_pkg::OP_ADD, 22, 20, 21, 0), NO_OP, 0, w);
        check_ready(1'b0); // rj waits for the product, rk forwards.
        issue_bundle(make_op(exe_pkg::OP_MUL, 23, 21, 21, 0), NO_OP, 1, w);
        issue_bundle(NO_OP, make_op(exe_pkg::OP_SUB, 24, 21, 23, 0), 0, w);
        check_ready(1'b0);
        drain();
    endtask

    task automatic zero_register();
        int w;
        issue_bundle(make_op(exe_pkg::OP_ADDI, 0, 0, 0, 16'h1234),
                     make_op(exe_pkg::OP_ADDI, 25, 0, 0, rnd16()), 1, w);
        issue_bundle(make_op(exe_pkg::OP_ADD, 26, 0, 0, 0), make_op(exe_pkg::OP_OR, 27, 0, 25, 0), 1, w);
        drain();
        issue_bundle(make_op(exe_pkg::OP_ADD, 28, 0, 0, 0), NO_OP, 1, w);
        drain();
    endtask

    task automatic divide_ops();
        int w;
        int divisor;
        issue_bundle(make_op(exe_pkg::OP_ADDI, 1, 0, 0, rnd16()),
                     make_op(exe_pkg::OP_ADDI, 2, 0, 0, rnd16()), 1, w);
        issue_bundle(make_op(exe_pkg::OP_MUL, 3, 1, 2, 0),
                     make_op(exe_pkg::OP_ADDI, 4, 0, 0, (rnd16() & 16'h7fff) | 16'h0001), 1, w);
        drain();
        for (int i = 0; i < 3; i++) begin
            divisor = (i == 0) ? 4 : (i == 1) ? 2 : 0;
            issue_bundle(make_op(exe_pkg::OP_DIV, 8, 3, divisor, 0),
                         make_op(exe_pkg::OP_ADDI, 9, 0, 0, rnd16()), 0, w);
            issue_bundle(make_op(exe_pkg::OP_ADD, 10, 8, 3, 0), NO_OP, 0, w);
            checks++;
            if (w != DIV_CYCLES + 1) begin
                errors++;
                $display("FAIL %0t ns: issue_ready_o low cycles expected %0d got %0d",
                         $time, DIV_CYCLES + 1, w);
            end
            drain();
        end
    endtask

    task automatic midrun_reset();
        int w;
        issue_bundle(make_op(exe_pkg::OP_ADDI, 1, 0, 0, rnd16()),
                     make_op(exe_pkg::OP_ADDI, 2, 0, 0, rnd16() | 16'h0001), 1, w);
        issue_bundle(make_op(exe_pkg::OP_DIV, 3, 1, 2, 0), NO_OP, 0, w);
        apply_reset(10); // kills both bundles before writeback.
        check_ready(1'b1);
        issue_bundle(make_op(exe_pkg::OP_ADD, 4, 1, 2, 0), NO_OP, 1, w);
        drain();
    endtask

    // compares each valid writeback lane against the expected queue.
    always @(negedge clk_i) begin
        for (int l = 0; l < 2; l++) begin
            if (wb_o[l].valid && exp_q.size() == 0) begin
                errors++;
                $display("ERROR: unexpected writeback to r%0d on lane %0d at %0t ns",
                         wb_o[l].rd, l, $time);
            end else if (wb_o[l].valid) begin
                mon_e = exp_q.pop_front();
                checks++;
                if (mon_e.lane != 1'(l)) begin
                    errors++;
                    $display("ERROR: writeback of r%0d came out on lane %0d", mon_e.rd, l);
                end
                if (wb_o[l].rd !== mon_e.rd) begin
                    errors++;
                    $display("FAIL %0t ns: wb_o[%0d].rd expected %0d got %0d",
                             $time, l, mon_e.rd, wb_o[l].rd);
                end
                if (wb_o[l].data !== mon_e.data) begin
                    errors++;
                    $display("FAIL %0t ns: wb_o[%0d].data expected %h got %h",
                             $time, l, mon_e.data, wb_o[l].data);
                end
                if (mon_e.exact && $time != mon_e.due) begin
                    errors++;
                    $display("FAIL %0t ns: wb_o[%0d].valid expected at %0d got at %0d",
                             $time, l, mon_e.due, $time);
                end
            end
        end
    end

    initial begin
        while ($time <= 2000 + bundles * 200 * CLK_NS) #(CLK_NS);
        errors++;
        $display("ERROR: watchdog expired at %0t ns, the run is stuck", $time);
        finish_run();
    end

    initial begin
        $timeformat(-9, 0, "", 0);
        void'($urandom(12));
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        apply_reset(10);
        @(posedge clk_i);
        #1;
        independent_ops();
        forwarding_paths();
        mul_stall();
        zero_register();
        divide_ops();
        midrun_reset();
        finish_run();
    end

endmodule

`default_nettype wire

// File: compile.f
exe_pkg.sv
ex1_forward.sv
exe_alu.sv
exe_regfile.sv
exe_ctrl.sv
div_unit.sv
exe_top.sv
exe_top_props.sv
tb_exe_top.sv

// File: Bender.yml
package:
  name: exe_cluster

sources:
  - files:
      - exe_pkg.sv
      - ex1_forward.sv
      - exe_alu.sv
      - exe_regfile.sv
      - exe_ctrl.sv
      - div_unit.sv
      - exe_top.sv
  - target: test
    files:
      - exe_top_props.sv
      - tb_exe_top.sv
